/* vlog.f */
design/uart_pkg.sv
design/byte_stream_if.sv
design/uart_rx.sv
design/uart_byte_fifo.sv
design/uart_tx.sv
design/uart_echo_top.sv
sim/tb_uart_echo.sv

/* Makefile */
# Verilator build for the UART echo bridge
TB_TOP = tb_uart_echo

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module uart_echo_top

sim:
	rm -f sim.log
	verilator --binary --timing -f vlog.f --top-module $(TB_TOP) -o $(TB_TOP)
	./obj_dir/$(TB_TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/tb_uart_echo.sv */
// Directed tests of the echo bridge at 8N1, bit time fixed by the package
// Serial lines are driven and sampled in clk cycles, so both ends share one clock

module tb_uart_echo;

	localparam int BIT_CLKS = uart_pkg::CLKS_PER_BIT;
	localparam int CHAR_CYCLES = 10 * BIT_CLKS; // Start, 8 data, 1 stop
	localparam int STORED_BYTES = uart_pkg::FIFO_DEPTH + 1; // FIFO plus tx holding register
	// Character times per test: single, burst, pause, framing, with slack for idle gaps
	localparam int TEST_CHARS = 4 + 23 + 23 + 6;
	localparam int TIMEOUT_CYCLES = TEST_CHARS * CHAR_CYCLES * 3 / 2;

	logic clk;
	logic sresetn;
	logic serial_in;
	logic tx_pause;
	logic serial_out;
	uart_pkg::err_count_t overrun_count;
	uart_pkg::err_count_t frame_error_count;

	int error_count = 0;
	int cycle_count = 0;
	logic [31:0] lcg_state = 32'd19626;
	uart_pkg::byte_t exp_q[$]; // Bytes that must come back, in order
	uart_pkg::byte_t rcv_q[$]; // Bytes seen on serial_out

	uart_echo_top i_dut (
		.clk (clk),
		.sresetn (sresetn),
		.serial_in (serial_in),
		.tx_pause (tx_pause),
		.serial_out (serial_out),
		.overrun_count (overrun_count),
		.frame_error_count (frame_error_count)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // Period 8
	end

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	// Watchdog
	initial begin
		while (cycle_count < TIMEOUT_CYCLES)
			@(posedge clk);
		$display("Run timed out after %0d cycles, echoes still missing", TIMEOUT_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("** Error at %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
			error_count++;
		end
	endtask

	// LCG step, middle bits are the better ones
	function automatic uart_pkg::byte_t lcg_byte();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	// One bit time on serial_in, set on a rising edge
	task automatic drive_bit(input logic level);
		@(posedge clk);
		serial_in <= level;
		repeat (BIT_CLKS - 1) @(posedge clk);
	endtask

	task automatic send_char(input uart_pkg::byte_t data, input logic stop_level);
		drive_bit(1'b0); // Start
		for (int i = 0; i < uart_pkg::DATA_BITS; i++)
			drive_bit(data[i]); // LSB first
		drive_bit(stop_level);
		if (!stop_level)
			drive_bit(1'b1); // Back to idle so the next start has an edge
	endtask

	// Samples on falling clk edges, away from the register updates
	task automatic capture_char(output uart_pkg::byte_t data);
		logic stop_bit;
		@(negedge clk);
		while (serial_out !== 1'b0)
			@(negedge clk);
		repeat (BIT_CLKS / 2 - 1) @(negedge clk); // Middle of start bit
		check(32'(serial_out), 32'd0, "start bit low at mid-bit");
		for (int i = 0; i < uart_pkg::DATA_BITS; i++) begin
			repeat (BIT_CLKS) @(negedge clk);
			data[i] = serial_out;
		end
		repeat (BIT_CLKS) @(negedge clk);
		stop_bit = serial_out;
		check(32'(stop_bit), 32'd1, "stop bit of echoed character high");
	endtask

	// Serial monitor, runs for the whole simulation
	initial begin
		uart_pkg::byte_t got;
		forever begin
			capture_char(got);
			rcv_q.push_back(got);
		end
	end

	// Waits for every expected echo, then a quiet gap to catch extra bytes
	task automatic compare_echoes(input string name);
		uart_pkg::byte_t want;
		uart_pkg::byte_t got;
		int idx;
		idx = 0;
		while (rcv_q.size() < exp_q.size())
			@(posedge clk);
		repeat (2 * CHAR_CYCLES) @(posedge clk);
		check(32'(rcv_q.size()), 32'(exp_q.size()), $sformatf("%s: echoed byte count", name));
		while (exp_q.size() > 0 && rcv_q.size() > 0) begin
			want = exp_q.pop_front();
			got = rcv_q.pop_front();
			check(32'(got), 32'(want), $sformatf("%s: echoed byte %0d", name, idx));
			idx++;
		end
		exp_q.delete();
		rcv_q.delete();
	endtask

	task automatic check_reset_state();
		repeat (20) begin
			@(negedge clk);
			check(32'(serial_out), 32'd1, "serial_out idle high after reset");
		end
		check(32'(overrun_count), 32'd0, "overrun_count zero after reset");
		check(32'(frame_error_count), 32'd0, "frame_error_count zero after reset");
	endtask

	task automatic echo_single_byte();
		uart_pkg::byte_t b;
		b = lcg_byte();
		exp_q.push_back(b);
		send_char(b, 1'b1);
		compare_echoes("single echo");
	endtask

	// Tx drains at line rate, so the FIFO never fills
	task automatic burst_in_order();
		uart_pkg::err_count_t ovr_start;
		uart_pkg::byte_t b;
		@(negedge clk);
		ovr_start = overrun_count;
		for (int i = 0; i < 20; i++) begin
			b = lcg_byte();
			exp_q.push_back(b);
			send_char(b, 1'b1); // Back to back, no idle gap
		end
		compare_echoes("burst");
		@(negedge clk);
		check(32'(overrun_count - ovr_start), 32'd0, "no overrun during burst");
	endtask

	task automatic overrun_while_paused();
		uart_pkg::err_count_t ovr_start;
		uart_pkg::byte_t b;
		@(negedge clk);
		ovr_start = overrun_count;
		@(posedge clk);
		tx_pause <= 1'b1;
		for (int i = 0; i < STORED_BYTES + 2; i++) begin
			b = lcg_byte();
			if (i < STORED_BYTES)
				exp_q.push_back(b); // Later ones have no storage
			send_char(b, 1'b1);
		end
		repeat (BIT_CLKS) @(negedge clk);
		check(32'(overrun_count - ovr_start), 32'd2, "overruns while paused");
		check(32'(rcv_q.size()), 32'd0, "nothing echoed while paused");
		@(posedge clk);
		tx_pause <= 1'b0;
		compare_echoes("pause release");
	endtask

	task automatic framing_error_dropped();
		uart_pkg::err_count_t fe_start;
		uart_pkg::byte_t b;
		@(negedge clk);
		fe_start = frame_error_count;
		b = lcg_byte();
		send_char(b, 1'b0); // Stop bit low, must not echo
		repeat (BIT_CLKS) @(negedge clk);
		check(32'(frame_error_count - fe_start), 32'd1, "frame error counted");
		b = lcg_byte();
		exp_q.push_back(b);
		send_char(b, 1'b1);
		compare_echoes("after framing error");
		@(negedge clk);
		check(32'(frame_error_count - fe_start), 32'd1, "good byte adds no frame error");
	endtask

	initial begin
		serial_in <= 1'b1; // Line idle
		tx_pause <= 1'b0;
		sresetn <= 1'b0;
		repeat (2) @(posedge clk);
		sresetn <= 1'b1;
		check_reset_state();
		echo_single_byte();
		burst_in_order();
		overrun_while_paused();
		framing_error_dropped();
		$display("Run finished with %0d errors", error_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* design/uart_echo_top.sv */
// Echoes every good byte received on serial_in back out on serial_out
// Paused bridge stores FIFO_DEPTH plus one bytes, later ones count as overruns

module uart_echo_top (
	input logic clk,
	input logic sresetn,
	input logic serial_in,
	input logic tx_pause,
	output logic serial_out,
	output uart_pkg::err_count_t overrun_count,
	output uart_pkg::err_count_t frame_error_count
);

	// Receiver to FIFO
	byte_stream_if rx_link (
		.clk (clk),
		.sresetn (sresetn)
	);

	// FIFO to transmitter holding register
	byte_stream_if tx_link (
		.clk (clk),
		.sresetn (sresetn)
	);

	uart_rx i_rx (
		.clk (clk),
		.sresetn (sresetn),
		.serial_in (serial_in),
		.out (rx_link.sender),
		.overrun_count (overrun_count),
		.frame_error_count (frame_error_count)
	);

	uart_byte_fifo i_fifo (
		.clk (clk),
		.sresetn (sresetn),
		.in (rx_link.receiver),
		.out (tx_link.sender)
	);

	uart_tx i_tx (
		.clk (clk),
		.sresetn (sresetn),
		.tx_pause (tx_pause),
		.in (tx_link.receiver),
		.serial_out (serial_out)
	);

endmodule

/* design/uart_tx.sv */
// One start bit, DATA_BITS data bits LSB first, exactly one stop bit
// tx_pause only blocks loading. A character in flight always finishes

module uart_tx (
	input logic clk,
	input logic sresetn,
	input logic tx_pause,
	byte_stream_if.receiver in,
	output logic serial_out
);

	uart_pkg::tx_state_t state;
	uart_pkg::baud_cnt_t baud_cnt;
	uart_pkg::bit_idx_t bit_idx;
	uart_pkg::byte_t shift_reg;
	uart_pkg::byte_t hold_data;
	logic hold_full;
	logic load;
	uart_pkg::byte_t load_data;
	logic bit_end;
	logic stop_end;

	// Take a held byte, or bypass a byte arriving this cycle
	assign load = (state == uart_pkg::TX_IDLE) && !tx_pause && (hold_full || in.valid);
	assign load_data = hold_full ? hold_data : in.data;
	assign in.credit_return = load; // Holding slot free again

	assign bit_end = (baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::CLKS_PER_BIT - 1));
	// Stop leaves a cycle early. The idle cycle after it completes the bit
	assign stop_end = (baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::CLKS_PER_BIT - 2));

	// Holding register flag
	always_ff @(posedge clk) begin
		if (!sresetn) begin
			hold_full <= 1'b0;
			in.ready_after_reset <= 1'b0;
		end else begin
			in.ready_after_reset <= 1'b1;
			if (load)
				hold_full <= 1'b0;
			else if (in.valid)
				hold_full <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (in.valid)
			hold_data <= in.data;
	end

	always_ff @(posedge clk) begin
		if (load)
			shift_reg <= load_data;
		else if (state == uart_pkg::TX_DATA && bit_end)
			shift_reg <= shift_reg >> 1; // Next bit to position 0
	end

	always_ff @(posedge clk) begin
		if (!sresetn) begin
			state <= uart_pkg::TX_IDLE;
			baud_cnt <= '0;
			bit_idx <= '0;
			serial_out <= 1'b1; // Line idles high
		end else begin
			baud_cnt <= baud_cnt + uart_pkg::baud_cnt_t'(1);
			case (state)
				uart_pkg::TX_IDLE: begin
					baud_cnt <= '0;
					if (load) begin
						serial_out <= 1'b0; // Start bit from next cycle
						state <= uart_pkg::TX_START;
					end
				end
				uart_pkg::TX_START: begin
					if (bit_end) begin
						baud_cnt <= '0;
						bit_idx <= '0;
						serial_out <= shift_reg[0];
						state <= uart_pkg::TX_DATA;
					end
				end
				uart_pkg::TX_DATA: begin
					if (bit_end) begin
						baud_cnt <= '0;
						if (bit_idx == uart_pkg::bit_idx_t'(uart_pkg::DATA_BITS - 1)) begin
							serial_out <= 1'b1;
							state <= uart_pkg::TX_STOP;
						end else begin
							serial_out <= shift_reg[1]; // Shift happens this same edge
							bit_idx <= bit_idx + uart_pkg::bit_idx_t'(1);
						end
					end
				end
				uart_pkg::TX_STOP: begin
					if (stop_end)
						state <= uart_pkg::TX_IDLE;
				end
				default: state <= uart_pkg::TX_IDLE;
			endcase
		end
	end

endmodule

/* design/uart_byte_fifo.sv */
// Never overflows since upstream credits equal FIFO_DEPTH
// Sends the oldest byte whenever it holds one and a downstream credit

module uart_byte_fifo (
	input logic clk,
	input logic sresetn,
	byte_stream_if.receiver in,
	byte_stream_if.sender out
);

	uart_pkg::byte_t mem [uart_pkg::FIFO_DEPTH];
	uart_pkg::fifo_ptr_t wr_ptr;
	uart_pkg::fifo_ptr_t rd_ptr;
	uart_pkg::credit_t fill; // Occupancy, same range as a credit count
	uart_pkg::credit_t tx_credits;
	logic tx_credits_loaded;
	logic send;

	// Combinational from registers only
	assign send = (fill != '0) && (tx_credits != '0);
	assign out.valid = send;
	assign out.data = mem[rd_ptr]; // Don't care while empty

	// Storage array
	always_ff @(posedge clk) begin
		if (in.valid)
			mem[wr_ptr] <= in.data;
	end

	always_ff @(posedge clk) begin
		if (!sresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			in.credit_return <= 1'b0;
			in.ready_after_reset <= 1'b0;
		end else begin
			in.ready_after_reset <= 1'b1;
			in.credit_return <= send; // Freed slot goes back next cycle
			if (in.valid)
				wr_ptr <= wr_ptr + uart_pkg::fifo_ptr_t'(1);
			if (send)
				rd_ptr <= rd_ptr + uart_pkg::fifo_ptr_t'(1);
			case ({in.valid, send})
				2'b10: fill <= fill + uart_pkg::credit_t'(1);
				2'b01: fill <= fill - uart_pkg::credit_t'(1);
				default: fill <= fill; // Push and pop together, or neither
			endcase
		end
	end

	// Credits toward the tx holding register
	always_ff @(posedge clk) begin
		if (!sresetn) begin
			tx_credits <= '0;
			tx_credits_loaded <= 1'b0;
		end else if (!tx_credits_loaded) begin
			if (out.ready_after_reset) begin
				tx_credits <= uart_pkg::credit_t'(uart_pkg::TX_HOLD_DEPTH);
				tx_credits_loaded <= 1'b1;
			end
		end else if (send && !out.credit_return) begin
			tx_credits <= tx_credits - uart_pkg::credit_t'(1);
		end else if (!send && out.credit_return) begin
			tx_credits <= tx_credits + uart_pkg::credit_t'(1);
		end
	end

endmodule

/* design/uart_rx.sv */
// No parity and no break detection. Any number of stop bits is accepted
// serial_in may be asynchronous to clk. A byte with no credit left is dropped

module uart_rx (
	input logic clk,
	input logic sresetn,
	input logic serial_in,
	byte_stream_if.sender out,
	output uart_pkg::err_count_t overrun_count,
	output uart_pkg::err_count_t frame_error_count
);

	logic sync_meta; // First sync flop
	logic sync_line; // Safe to use
	logic line_prev; // For edge detect
	logic fall_edge;
	uart_pkg::rx_state_t state;
	uart_pkg::baud_cnt_t baud_cnt;
	uart_pkg::bit_idx_t bit_idx;
	uart_pkg::byte_t shift_reg;
	uart_pkg::credit_t credits;
	logic credits_loaded;
	logic half_bit;
	logic bit_end;

	// Two flops against metastability, idle level during reset
	always_ff @(posedge clk) begin
		if (!sresetn) begin
			sync_meta <= 1'b1;
			sync_line <= 1'b1;
			line_prev <= 1'b1;
		end else begin
			sync_meta <= serial_in;
			sync_line <= sync_meta;
			line_prev <= sync_line;
		end
	end

	assign fall_edge = line_prev && !sync_line;

	// Middle of start bit, then middle of every later bit
	assign half_bit = (baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::CLKS_PER_BIT/2 - 1));
	assign bit_end = (baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::CLKS_PER_BIT - 1));

	always_ff @(posedge clk) begin
		if (!sresetn) begin
			state <= uart_pkg::RX_IDLE;
			baud_cnt <= '0;
			bit_idx <= '0;
			out.valid <= 1'b0;
			overrun_count <= '0;
			frame_error_count <= '0;
		end else begin
			out.valid <= 1'b0; // Single cycle pulse
			baud_cnt <= baud_cnt + uart_pkg::baud_cnt_t'(1);
			case (state)
				uart_pkg::RX_IDLE: begin
					baud_cnt <= '0;
					if (fall_edge)
						state <= uart_pkg::RX_START;
				end
				uart_pkg::RX_START: begin
					if (half_bit) begin
						baud_cnt <= '0;
						bit_idx <= '0;
						// Glitch if line is back high
						state <= sync_line ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
					end
				end
				uart_pkg::RX_DATA: begin
					if (bit_end) begin
						baud_cnt <= '0;
						bit_idx <= bit_idx + uart_pkg::bit_idx_t'(1);
						if (bit_idx == uart_pkg::bit_idx_t'(uart_pkg::DATA_BITS - 1))
							state <= uart_pkg::RX_STOP;
					end
				end
				uart_pkg::RX_STOP: begin
					if (bit_end) begin
						state <= uart_pkg::RX_IDLE; // Extra stop bits just look idle
						if (!sync_line)
							frame_error_count <= frame_error_count + uart_pkg::err_count_t'(1);
						else if (credits == '0)
							overrun_count <= overrun_count + uart_pkg::err_count_t'(1);
						else
							out.valid <= 1'b1;
					end
				end
				default: state <= uart_pkg::RX_IDLE;
			endcase
		end
	end

	// LSB first, new bit enters at the top
	always_ff @(posedge clk) begin
		if (state == uart_pkg::RX_DATA && bit_end)
			shift_reg <= {sync_line, shift_reg[uart_pkg::DATA_BITS-1:1]};
	end

	assign out.data = shift_reg; // Stable from last data bit until next start

	// Credits toward the FIFO
	always_ff @(posedge clk) begin
		if (!sresetn) begin
			credits <= '0;
			credits_loaded <= 1'b0;
		end else if (!credits_loaded) begin
			if (out.ready_after_reset) begin
				credits <= uart_pkg::credit_t'(uart_pkg::FIFO_DEPTH);
				credits_loaded <= 1'b1;
			end
		end else if (out.valid && !out.credit_return) begin
			credits <= credits - uart_pkg::credit_t'(1);
		end else if (!out.valid && out.credit_return) begin
			credits <= credits + uart_pkg::credit_t'(1);
		end
	end

endmodule

/* design/byte_stream_if.sv */
// Sender starts with credit equal to the receiver's storage, once ready_after_reset is high
// One valid pulse moves one byte. Receiver must take every beat

interface byte_stream_if (
	input logic clk,
	input logic sresetn
);

	logic valid; // One byte per cycle high
	uart_pkg::byte_t data;
	logic credit_return; // One credit per cycle high
	logic ready_after_reset; // Low in reset, high from first cycle after

	modport sender (
		input clk,
		input sresetn,
		output valid,
		output data,
		input credit_return,
		input ready_after_reset
	);

	modport receiver (
		input clk,
		input sresetn,
		input valid,
		input data,
		output credit_return,
		output ready_after_reset
	);

endinterface

/* design/uart_pkg.sv */
// Fixed 8N1 format and bit time. Nothing here is set at run time
// Enum labels carry RX_/TX_ prefixes so both machines share one package

package uart_pkg;

	// Character format and timing
	localparam int DATA_BITS = 8;
	localparam int CLKS_PER_BIT = 16; // Kept short for fast simulation

	// Storage on each link
	localparam int FIFO_DEPTH = 8; // Power of two, pointers wrap naturally
	localparam int TX_HOLD_DEPTH = 1; // One-byte holding register in uart_tx

	typedef logic [DATA_BITS-1:0] byte_t;

	// Counts 0 to FIFO_DEPTH
	typedef logic [$clog2(FIFO_DEPTH+1)-1:0] credit_t;

	typedef logic [15:0] err_count_t; // Wraps silently

	typedef logic [$clog2(CLKS_PER_BIT)-1:0] baud_cnt_t;
	typedef logic [$clog2(DATA_BITS)-1:0] bit_idx_t;
	typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_ptr_t;

	typedef enum logic [1:0] {
		RX_IDLE, // Waiting for a falling edge
		RX_START, // Recheck start bit at half a bit
		RX_DATA,
		RX_STOP
	} rx_state_t;

	typedef enum logic [1:0] {
		TX_IDLE, // Line high, ready to load
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

endpackage
